// ==== hw/eth_tx_pkg.sv ====
package eth_tx_pkg;

	////////////////////
	// Field widths
	////////////////////

	// MAC address
	localparam int mac_w = 48;

	// Ethertype field
	localparam int ethertype_w = 16;

	// Payload byte count, wide enough for jumbo frames
	localparam int frame_len_w = 14;

	// Header FIFO word is {length, ethertype, dst MAC}
	localparam int header_w = frame_len_w + ethertype_w + mac_w;

	// Free payload words required before a frame is admitted
	localparam int min_frame_words = 8;

	////////////////////
	// Payload word
	////////////////////

	// One 32-bit FIFO word, seen whole or as bytes
	// Byte 0 is the most significant and goes out first
	typedef union packed {
		logic [31:0]     word;
		logic [0:3][7:0] bytes;
	} payload_word_t;

endpackage

// ==== hw/tx_l2_writer.sv ====
module tx_l2_writer #(
	parameter int packet_depth = 8192,
	parameter int header_depth = 512
) (
	input  logic                                    mac_tx_clk,
	input  logic                                    arst_n,
	input  logic                                    tx_l2_start,
	input  logic                                    tx_l2_data_valid,
	input  logic [31:0]                             tx_l2_data,
	input  logic [2:0]                              tx_l2_bytes_valid,
	input  logic                                    tx_l2_commit,
	input  logic                                    tx_l2_drop,
	input  logic [eth_tx_pkg::ethertype_w-1:0]      tx_l2_ethertype,
	input  logic [eth_tx_pkg::mac_w-1:0]            tx_l2_dst_mac,
	input  logic [$clog2(packet_depth):0]           pkt_wr_free,
	input  logic [$clog2(header_depth):0]           hdr_wr_free,
	output logic                                    pkt_wr_en,
	output eth_tx_pkg::payload_word_t               pkt_wr_data,
	output logic                                    pkt_commit,
	output logic                                    pkt_rollback,
	output logic                                    hdr_wr_en,
	output logic [eth_tx_pkg::header_w-1:0]         hdr_wr_data
);

	// Frame in progress and accepted
	logic                               packet_active;
	// Payload bytes written so far
	logic [eth_tx_pkg::frame_len_w-1:0] byte_count;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge mac_tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			packet_active <= 1'b0;
			byte_count    <= '0;
			pkt_wr_en     <= 1'b0;
			pkt_commit    <= 1'b0;
			pkt_rollback  <= 1'b0;
			hdr_wr_en     <= 1'b0;
		end else begin
			// Strobes last one cycle
			pkt_wr_en    <= 1'b0;
			pkt_commit   <= 1'b0;
			pkt_rollback <= 1'b0;
			hdr_wr_en    <= 1'b0;

			if (!packet_active) begin
				// Admit only with a header slot and a minimum frame of payload room
				// Refused frames are simply ignored until the next start
				if (tx_l2_start) begin
					byte_count <= '0;
					if (hdr_wr_free >= 1 && pkt_wr_free >= eth_tx_pkg::min_frame_words)
						packet_active <= 1'b1;
				end
			end else if (tx_l2_commit) begin
				// Payload and header become visible together
				pkt_commit    <= 1'b1;
				hdr_wr_en     <= 1'b1;
				packet_active <= 1'b0;
			end else if (tx_l2_drop) begin
				pkt_rollback  <= 1'b1;
				packet_active <= 1'b0;
			end else if (tx_l2_data_valid) begin
				// Out of room, discard the partial frame
				if (pkt_wr_free <= 1) begin
					pkt_rollback  <= 1'b1;
					packet_active <= 1'b0;
				end else begin
					pkt_wr_en  <= 1'b1;
					byte_count <= byte_count + eth_tx_pkg::frame_len_w'(tx_l2_bytes_valid);
				end
			end
		end
	end

	////////////////////
	// Data registers
	////////////////////

	always_ff @(posedge mac_tx_clk) begin
		pkt_wr_data.word <= tx_l2_data;
		// Header fields are valid during the commit pulse
		if (tx_l2_commit)
			hdr_wr_data <= {byte_count, tx_l2_ethertype, tx_l2_dst_mac};
	end

endmodule

// ==== hw/packet_fifo.sv ====
module packet_fifo #(
	parameter int packet_depth = 8192
) (
	input  logic                              mac_tx_clk,
	input  logic                              arst_n,
	input  logic                              pkt_wr_en,
	input  eth_tx_pkg::payload_word_t         pkt_wr_data,
	input  logic                              pkt_commit,
	input  logic                              pkt_rollback,
	input  logic                              pkt_rd_en,
	input  logic [$clog2(packet_depth)-1:0]   pkt_rd_offset,
	input  logic                              pkt_pop,
	input  logic [$clog2(packet_depth):0]     pkt_pop_words,
	output logic [$clog2(packet_depth):0]     pkt_wr_free,
	output eth_tx_pkg::payload_word_t         pkt_rd_data,
	output logic [$clog2(packet_depth):0]     pkt_rd_committed
);

	localparam int addr_w = $clog2(packet_depth);
	localparam int ptr_w  = addr_w + 1;

	// Word storage
	logic [31:0] mem [packet_depth];

	// Pointers carry one extra bit to tell full from empty
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] wr_ptr_committed;
	logic [ptr_w-1:0] rd_ptr;

	// Read address relative to the head of the oldest frame
	logic [addr_w-1:0] rd_addr;

	////////////////////
	// Pointers
	////////////////////

	always_ff @(posedge mac_tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr           <= '0;
			wr_ptr_committed <= '0;
			rd_ptr           <= '0;
		end else begin
			// Rollback rewinds to the last commit point
			if (pkt_rollback)
				wr_ptr <= wr_ptr_committed;
			else if (pkt_wr_en)
				wr_ptr <= wr_ptr + 1'b1;

			// Words written so far become readable
			if (pkt_commit)
				wr_ptr_committed <= wr_ptr;

			// Release a whole frame at once
			if (pkt_pop)
				rd_ptr <= rd_ptr + pkt_pop_words;
		end
	end

	////////////////////
	// Storage
	////////////////////

	assign rd_addr = rd_ptr[addr_w-1:0] + pkt_rd_offset;

	always_ff @(posedge mac_tx_clk) begin
		if (pkt_wr_en)
			mem[wr_ptr[addr_w-1:0]] <= pkt_wr_data.word;
		// One cycle read latency
		if (pkt_rd_en)
			pkt_rd_data.word <= mem[rd_addr];
	end

	// Free space counts uncommitted words as used
	assign pkt_wr_free      = ptr_w'(packet_depth) - (wr_ptr - rd_ptr);
	// Reader only sees committed words
	assign pkt_rd_committed = wr_ptr_committed - rd_ptr;

endmodule

// ==== hw/header_fifo.sv ====
module header_fifo #(
	parameter int header_depth = 512
) (
	input  logic                              mac_tx_clk,
	input  logic                              arst_n,
	input  logic                              hdr_wr_en,
	input  logic [eth_tx_pkg::header_w-1:0]   hdr_wr_data,
	input  logic                              hdr_rd_en,
	output logic [$clog2(header_depth):0]     hdr_wr_free,
	output logic [eth_tx_pkg::header_w-1:0]   hdr_rd_data,
	output logic [$clog2(header_depth):0]     hdr_rd_count
);

	localparam int addr_w = $clog2(header_depth);
	localparam int ptr_w  = addr_w + 1;

	// One slot per queued frame
	logic [eth_tx_pkg::header_w-1:0] mem [header_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;

	always_ff @(posedge mac_tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (hdr_wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			// Reading an entry also pops it
			if (hdr_rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge mac_tx_clk) begin
		if (hdr_wr_en)
			mem[wr_ptr[addr_w-1:0]] <= hdr_wr_data;
		if (hdr_rd_en)
			hdr_rd_data <= mem[rd_ptr[addr_w-1:0]];
	end

	assign hdr_wr_free  = ptr_w'(header_depth) - (wr_ptr - rd_ptr);
	assign hdr_rd_count = wr_ptr - rd_ptr;

endmodule

// ==== hw/tx_frame_reader.sv ====
module tx_frame_reader #(
	parameter int packet_depth = 8192,
	parameter int header_depth = 512
) (
	input  logic                              mac_tx_clk,
	input  logic                              arst_n,
	input  logic [eth_tx_pkg::mac_w-1:0]      our_mac_address,
	input  logic                              mac_tx_ready,
	input  logic [$clog2(header_depth):0]     hdr_rd_count,
	input  logic [eth_tx_pkg::header_w-1:0]   hdr_rd_data,
	input  logic [$clog2(packet_depth):0]     pkt_rd_committed,
	input  eth_tx_pkg::payload_word_t         pkt_rd_data,
	output logic                              hdr_rd_en,
	output logic                              pkt_rd_en,
	output logic [$clog2(packet_depth)-1:0]   pkt_rd_offset,
	output logic                              pkt_pop,
	output logic [$clog2(packet_depth):0]     pkt_pop_words,
	output logic                              mac_tx_start,
	output logic                              mac_tx_data_valid,
	output logic [7:0]                        mac_tx_data
);

	localparam int ptr_w   = $clog2(packet_depth) + 1;
	localparam int len_w   = eth_tx_pkg::frame_len_w;
	localparam int shift_w = 2 * eth_tx_pkg::mac_w + eth_tx_pkg::ethertype_w;

	logic                 tx_active;
	// 0..13 header, 14..17 payload bytes, 18 pop
	logic [4:0]           tx_count;
	logic [len_w-1:0]     tx_bytes_left;
	logic                 hdr_rd_en_ff;
	// Dst MAC, our MAC and ethertype, shifted out MSB first
	logic [shift_w-1:0]   hdr_shift;
	logic [len_w-1:0]     hdr_len;
	logic [1:0]           byte_sel;

	assign hdr_len  = hdr_rd_data[eth_tx_pkg::header_w-1 -: len_w];
	// Payload states 14..17 map to bytes 0..3
	assign byte_sel = tx_count[1:0] + 2'd2;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge mac_tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_active         <= 1'b0;
			tx_count          <= '0;
			tx_bytes_left     <= '0;
			hdr_rd_en         <= 1'b0;
			hdr_rd_en_ff      <= 1'b0;
			pkt_rd_en         <= 1'b0;
			pkt_rd_offset     <= '0;
			pkt_pop           <= 1'b0;
			pkt_pop_words     <= '0;
			mac_tx_start      <= 1'b0;
			mac_tx_data_valid <= 1'b0;
		end else begin
			hdr_rd_en         <= 1'b0;
			pkt_rd_en         <= 1'b0;
			pkt_pop           <= 1'b0;
			mac_tx_start      <= 1'b0;
			mac_tx_data_valid <= 1'b0;
			hdr_rd_en_ff      <= hdr_rd_en;

			if (!tx_active) begin
				// Pop cycle, committed count is stale
				if (pkt_pop) begin
				end else if (hdr_rd_en_ff) begin
					// Header word is out, start the frame
					tx_active     <= 1'b1;
					tx_count      <= '0;
					mac_tx_start  <= 1'b1;
					tx_bytes_left <= hdr_len;
					// Round the frame up to whole words
					pkt_pop_words <= ptr_w'(hdr_len[len_w-1:2]) + ptr_w'(|hdr_len[1:0]);
				end else if (!hdr_rd_en && hdr_rd_count != 0 && pkt_rd_committed != 0
						&& mac_tx_ready) begin
					hdr_rd_en <= 1'b1;
				end
			end else if (tx_count < 5'd14) begin
				mac_tx_data_valid <= 1'b1;
				tx_count          <= tx_count + 1'b1;
				// First payload word lands in time for state 14
				if (tx_count == 5'd11) begin
					pkt_rd_en     <= 1'b1;
					pkt_rd_offset <= '0;
				end
			end else if (tx_count == 5'd18) begin
				pkt_pop   <= 1'b1;
				tx_active <= 1'b0;
				tx_count  <= '0;
			end else begin
				mac_tx_data_valid <= 1'b1;
				// Prefetch next word when bytes remain past this one
				if (tx_count == 5'd16 && tx_bytes_left >= 5) begin
					pkt_rd_en     <= 1'b1;
					pkt_rd_offset <= pkt_rd_offset + 1'b1;
				end
				// Last byte of the frame just went out
				if (tx_bytes_left <= len_w'(byte_sel) + 1'b1) begin
					tx_count <= 5'd18;
				end else if (tx_count == 5'd17) begin
					tx_count      <= 5'd14;
					tx_bytes_left <= tx_bytes_left - len_w'(4);
				end else begin
					tx_count <= tx_count + 1'b1;
				end
			end
		end
	end

	////////////////////
	// Byte datapath
	////////////////////

	always_ff @(posedge mac_tx_clk) begin
		if (!tx_active && hdr_rd_en_ff) begin
			hdr_shift <= {hdr_rd_data[eth_tx_pkg::mac_w-1:0], our_mac_address,
				hdr_rd_data[eth_tx_pkg::mac_w +: eth_tx_pkg::ethertype_w]};
		end else if (tx_active && tx_count < 5'd14) begin
			mac_tx_data <= hdr_shift[shift_w-1 -: 8];
			hdr_shift   <= hdr_shift << 8;
		end else if (tx_active && tx_count != 5'd18) begin
			mac_tx_data <= pkt_rd_data.bytes[byte_sel];
		end
	end

endmodule

// ==== hw/eth_tx_buffer.sv ====
module eth_tx_buffer #(
	parameter int packet_depth = 8192,
	parameter int header_depth = 512
) (
	input  logic                               mac_tx_clk,
	input  logic                               arst_n,
	input  logic                               tx_l2_start,
	input  logic                               tx_l2_data_valid,
	input  logic [31:0]                        tx_l2_data,
	input  logic [2:0]                         tx_l2_bytes_valid,
	input  logic                               tx_l2_commit,
	input  logic                               tx_l2_drop,
	input  logic [eth_tx_pkg::ethertype_w-1:0] tx_l2_ethertype,
	input  logic [eth_tx_pkg::mac_w-1:0]       tx_l2_dst_mac,
	input  logic [eth_tx_pkg::mac_w-1:0]       our_mac_address,
	input  logic                               mac_tx_ready,
	output logic                               mac_tx_start,
	output logic                               mac_tx_data_valid,
	output logic [7:0]                         mac_tx_data
);

	localparam int pkt_addr_w = $clog2(packet_depth);
	localparam int hdr_addr_w = $clog2(header_depth);

	////////////////////
	// Payload FIFO nets
	////////////////////

	logic                            pkt_wr_en;
	eth_tx_pkg::payload_word_t       pkt_wr_data;
	logic                            pkt_commit;
	logic                            pkt_rollback;
	logic [pkt_addr_w:0]             pkt_wr_free;
	logic                            pkt_rd_en;
	logic [pkt_addr_w-1:0]           pkt_rd_offset;
	logic                            pkt_pop;
	logic [pkt_addr_w:0]             pkt_pop_words;
	eth_tx_pkg::payload_word_t       pkt_rd_data;
	logic [pkt_addr_w:0]             pkt_rd_committed;

	////////////////////
	// Header FIFO nets
	////////////////////

	logic                            hdr_wr_en;
	logic [eth_tx_pkg::header_w-1:0] hdr_wr_data;
	logic [hdr_addr_w:0]             hdr_wr_free;
	logic                            hdr_rd_en;
	logic [eth_tx_pkg::header_w-1:0] hdr_rd_data;
	logic [hdr_addr_w:0]             hdr_rd_count;

	// Layer-2 write side
	tx_l2_writer #(
		.packet_depth(packet_depth),
		.header_depth(header_depth)
	) u_writer (
		.mac_tx_clk, .arst_n,
		.tx_l2_start, .tx_l2_data_valid, .tx_l2_data, .tx_l2_bytes_valid,
		.tx_l2_commit, .tx_l2_drop, .tx_l2_ethertype, .tx_l2_dst_mac,
		.pkt_wr_free, .hdr_wr_free,
		.pkt_wr_en, .pkt_wr_data, .pkt_commit, .pkt_rollback,
		.hdr_wr_en, .hdr_wr_data
	);

	packet_fifo #(
		.packet_depth(packet_depth)
	) u_packet_fifo (
		.mac_tx_clk, .arst_n,
		.pkt_wr_en, .pkt_wr_data, .pkt_commit, .pkt_rollback,
		.pkt_rd_en, .pkt_rd_offset, .pkt_pop, .pkt_pop_words,
		.pkt_wr_free, .pkt_rd_data, .pkt_rd_committed
	);

	header_fifo #(
		.header_depth(header_depth)
	) u_header_fifo (
		.mac_tx_clk, .arst_n,
		.hdr_wr_en, .hdr_wr_data, .hdr_rd_en,
		.hdr_wr_free, .hdr_rd_data, .hdr_rd_count
	);

	// MAC byte side
	tx_frame_reader #(
		.packet_depth(packet_depth),
		.header_depth(header_depth)
	) u_reader (
		.mac_tx_clk, .arst_n,
		.our_mac_address, .mac_tx_ready,
		.hdr_rd_count, .hdr_rd_data, .pkt_rd_committed, .pkt_rd_data,
		.hdr_rd_en, .pkt_rd_en, .pkt_rd_offset, .pkt_pop, .pkt_pop_words,
		.mac_tx_start, .mac_tx_data_valid, .mac_tx_data
	);

endmodule

// ==== testbench/tb_frame_table.svh ====
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// Driver actions
localparam int act_commit = 0;
localparam int act_drop   = 1;
// Commit with mac_tx_ready held low so the frame only queues
localparam int act_hold   = 2;

localparam int n_entries = 19;

// Columns: name, payload bytes, ethertype, destination MAC, action, expected on the wire
string       row_name   [n_entries];
int          row_len    [n_entries];
logic [15:0] row_type   [n_entries];
logic [47:0] row_dst    [n_entries];
int          row_action [n_entries];
bit          row_expect [n_entries];
int          row_count;

task automatic add_row(input string name, input int len, input logic [15:0] etype,
		input logic [47:0] dst, input int action, input bit expect_out);
	row_name[row_count]   = name;
	row_len[row_count]    = len;
	row_type[row_count]   = etype;
	row_dst[row_count]    = dst;
	row_action[row_count] = action;
	row_expect[row_count] = expect_out;
	row_count++;
endtask

task automatic load_frame_table();
	row_count = 0;
	// Every short length, partial and whole last words
	add_row("len_1", 1, 16'h0800, 48'h0a_11_22_33_44_01, act_commit, 1'b1);
	add_row("len_2", 2, 16'h86dd, 48'h0a_11_22_33_44_02, act_commit, 1'b1);
	add_row("len_3", 3, 16'h0806, 48'h0a_11_22_33_44_03, act_commit, 1'b1);
	add_row("len_4", 4, 16'h0800, 48'h0a_11_22_33_44_04, act_commit, 1'b1);
	add_row("len_5", 5, 16'h88b5, 48'h0a_11_22_33_44_05, act_commit, 1'b1);
	add_row("len_6", 6, 16'h0800, 48'h0a_11_22_33_44_06, act_commit, 1'b1);
	add_row("len_7", 7, 16'h1234, 48'h0a_11_22_33_44_07, act_commit, 1'b1);
	add_row("len_8", 8, 16'h0800, 48'h0a_11_22_33_44_08, act_commit, 1'b1);
	add_row("len_9", 9, 16'hfedc, 48'h0a_11_22_33_44_09, act_commit, 1'b1);
	// Dropped frame, then one that must arrive intact
	add_row("drop_mid", 12, 16'h0800, 48'h0a_11_22_33_44_0a, act_drop, 1'b0);
	add_row("after_drop", 10, 16'h0806, 48'h0a_11_22_33_44_0b, act_commit, 1'b1);
	// Three frames queue while the MAC is not ready
	add_row("hold_a", 20, 16'h0800, 48'h0a_11_22_33_44_0c, act_hold, 1'b1);
	add_row("hold_b", 7, 16'h86dd, 48'h0a_11_22_33_44_0d, act_hold, 1'b1);
	add_row("hold_c", 33, 16'h0800, 48'h0a_11_22_33_44_0e, act_hold, 1'b1);
	// 35 words never fit in 32
	add_row("overflow_long", 140, 16'h0800, 48'h0a_11_22_33_44_0f, act_commit, 1'b0);
	add_row("after_overflow", 6, 16'h0800, 48'h0a_11_22_33_44_10, act_commit, 1'b1);
	// 25 words queued leave 7 free, so the next start is refused
	add_row("big_hold", 100, 16'h0800, 48'h0a_11_22_33_44_11, act_hold, 1'b1);
	add_row("refused", 8, 16'h0806, 48'h0a_11_22_33_44_12, act_hold, 1'b0);
	add_row("after_refused", 5, 16'h0800, 48'h0a_11_22_33_44_13, act_commit, 1'b1);
endtask

`endif

// ==== testbench/tb_eth_tx_buffer.sv ====
module tb_eth_tx_buffer;

	logic        mac_tx_clk;
	logic        arst_n;
	logic        tx_l2_start;
	logic        tx_l2_data_valid;
	logic [31:0] tx_l2_data;
	logic [2:0]  tx_l2_bytes_valid;
	logic        tx_l2_commit;
	logic        tx_l2_drop;
	logic [15:0] tx_l2_ethertype;
	logic [47:0] tx_l2_dst_mac;
	logic [47:0] our_mac_address;
	logic        mac_tx_ready;
	logic        mac_tx_start;
	logic        mac_tx_data_valid;
	logic [7:0]  mac_tx_data;

	// Expected wire bytes of every frame still to arrive, in commit order
	logic [7:0]  exp_bytes [$];
	int          exp_lens [$];
	string       exp_names [$];
	// Bytes of the frame being received
	logic [7:0]  rx_bytes [$];
	bit          in_frame;

	int          errors;
	int          frames_queued;
	int          frames_done;
	int          ready_low_cycles;
	int          cycles;
	int          cycle_limit;
	int unsigned lcg_state = 3107;

	`include "tb_frame_table.svh"

	eth_tx_buffer #(
		.packet_depth(32)
	) u_dut (
		.mac_tx_clk, .arst_n,
		.tx_l2_start, .tx_l2_data_valid, .tx_l2_data, .tx_l2_bytes_valid,
		.tx_l2_commit, .tx_l2_drop, .tx_l2_ethertype, .tx_l2_dst_mac,
		.our_mac_address, .mac_tx_ready,
		.mac_tx_start, .mac_tx_data_valid, .mac_tx_data
	);

	initial begin
		mac_tx_clk = 1'b0;
		forever #20 mac_tx_clk = ~mac_tx_clk;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [7:0] next_payload_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Inputs change shortly after the rising edge
	task automatic step();
		@(posedge mac_tx_clk);
		#2;
	endtask

	task automatic wait_for_frames();
		while (frames_done < frames_queued)
			@(negedge mac_tx_clk);
	endtask

	////////////////////
	// Driver
	////////////////////

	task automatic drive_frame(input int idx);
		int          n_words;
		int          w;
		int          b;
		int          nb;
		logic [31:0] word;
		logic [7:0]  pb;
		n_words = (row_len[idx] + 3) / 4;
		// Dst MAC, our MAC, ethertype, all MSB first
		if (row_expect[idx]) begin
			for (b = 0; b < 6; b++)
				exp_bytes.push_back(row_dst[idx][47-8*b -: 8]);
			for (b = 0; b < 6; b++)
				exp_bytes.push_back(our_mac_address[47-8*b -: 8]);
			exp_bytes.push_back(row_type[idx][15:8]);
			exp_bytes.push_back(row_type[idx][7:0]);
		end
		step();
		tx_l2_start     = 1'b1;
		tx_l2_ethertype = row_type[idx];
		tx_l2_dst_mac   = row_dst[idx];
		for (w = 0; w < n_words; w++) begin
			step();
			tx_l2_start = 1'b0;
			nb = row_len[idx] - 4 * w;
			if (nb > 4)
				nb = 4;
			word = '0;
			// Byte 0 rides in the top lane
			for (b = 0; b < nb; b++) begin
				pb = next_payload_byte();
				word[31-8*b -: 8] = pb;
				if (row_expect[idx])
					exp_bytes.push_back(pb);
			end
			tx_l2_data_valid  = 1'b1;
			tx_l2_data        = word;
			tx_l2_bytes_valid = 3'(nb);
		end
		step();
		tx_l2_data_valid = 1'b0;
		tx_l2_commit     = (row_action[idx] != act_drop);
		tx_l2_drop       = (row_action[idx] == act_drop);
		step();
		tx_l2_commit = 1'b0;
		tx_l2_drop   = 1'b0;
		if (row_expect[idx]) begin
			exp_lens.push_back(row_len[idx]);
			exp_names.push_back(row_name[idx]);
			frames_queued++;
		end
	endtask

	task automatic run_entry(input int idx);
		step();
		// Held frames queue, others go out once the queue is empty
		if (row_action[idx] == act_hold) begin
			mac_tx_ready = 1'b0;
		end else begin
			mac_tx_ready = 1'b1;
			wait_for_frames();
		end
		drive_frame(idx);
		if (row_action[idx] != act_hold) begin
			wait_for_frames();
			repeat (4) step();
		end
	endtask

	////////////////////
	// Monitor
	////////////////////

	task automatic check_frame();
		string      name;
		int         len;
		int         i;
		logic [7:0] e;
		name = exp_names.pop_front();
		len  = exp_lens.pop_front();
		compare_value({name, " length"}, 14 + len, rx_bytes.size());
		for (i = 0; i < 14 + len; i++) begin
			e = exp_bytes.pop_front();
			if (i < rx_bytes.size())
				compare_value($sformatf("%s byte %0d", name, i), e, rx_bytes[i]);
		end
		frames_done++;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge mac_tx_clk) begin
		if (arst_n) begin
			if (mac_tx_ready)
				ready_low_cycles = 0;
			else
				ready_low_cycles++;
			if (mac_tx_start) begin
				if (ready_low_cycles >= 4) begin
					errors++;
					$display("A frame started while mac_tx_ready was low");
				end
				if (in_frame) begin
					errors++;
					$display("mac_tx_start pulsed inside a frame");
				end
				in_frame = 1'b1;
				rx_bytes.delete();
			end else if (in_frame) begin
				if (mac_tx_data_valid) begin
					rx_bytes.push_back(mac_tx_data);
				end else if (rx_bytes.size() > 0) begin
					// First gap ends the frame
					in_frame = 1'b0;
					if (exp_lens.size() == 0) begin
						errors++;
						$display("A frame of %0d bytes came out but none was expected",
							rx_bytes.size());
					end else begin
						check_frame();
					end
				end
			end else if (mac_tx_data_valid) begin
				errors++;
				$display("mac_tx_data_valid was high outside a frame");
			end
		end
	end

	// Run limit from the table's total wire bytes
	always @(posedge mac_tx_clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, %0d of %0d frames received",
				cycles, frames_done, frames_queued);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////
	// Sequence
	////////////////////

	initial begin
		int i;
		int total;
		arst_n            = 1'b0;
		tx_l2_start       = 1'b0;
		tx_l2_data_valid  = 1'b0;
		tx_l2_data        = '0;
		tx_l2_bytes_valid = '0;
		tx_l2_commit      = 1'b0;
		tx_l2_drop        = 1'b0;
		tx_l2_ethertype   = '0;
		tx_l2_dst_mac     = '0;
		our_mac_address   = 48'h02_a0_c9_5e_71_3c;
		mac_tx_ready      = 1'b1;
		load_frame_table();
		total = 0;
		for (i = 0; i < n_entries; i++)
			total += row_len[i] + 14;
		cycle_limit = total * 2 + 200 * n_entries;

		repeat (4) @(posedge mac_tx_clk);
		#2;
		arst_n = 1'b1;
		// Nothing committed, so the MAC side stays quiet
		repeat (20) step();

		for (i = 0; i < n_entries; i++)
			run_entry(i);
		step();
		mac_tx_ready = 1'b1;
		wait_for_frames();
		// Catch late or repeated frames
		repeat (40) step();
		// A start pulse with no bytes behind it leaves the frame open
		if (in_frame) begin
			errors++;
			$display("A frame was still open at the end of the run");
		end

		$display("Frames checked %0d of %0d, errors %0d", frames_done, frames_queued, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
hw/eth_tx_pkg.sv
hw/tx_l2_writer.sv
hw/packet_fifo.sv
hw/header_fifo.sv
hw/tx_frame_reader.sv
hw/eth_tx_buffer.sv
testbench/tb_eth_tx_buffer.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eth_tx_buffer
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) testbench/tb_frame_table.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "No pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
